// ==== Bender.yml ====
package:
  name: mem_tile

sources:
  - files:
      - design/mem_tile_pkg.sv
      - design/mem_bank_if.sv
      - design/sram_macro.sv
      - design/mem_atomic_unit.sv
      - design/mem_bank_array.sv
      - design/mem_tile.sv
  - target: test
    files:
      - verification/mem_tile_tb.sv

// ==== design/mem_atomic_unit.sv ====
// Atomic resolver
// Passes plain accesses to the banks and turns AMOs and LR/SC into a
// read followed by a write-back, with a single LR reservation

`timescale 1ns/1ps

module mem_atomic_unit (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_i,
  output logic                    gnt_o,
  input  mem_tile_pkg::addr_t     addr_i,
  input  logic                    we_i,
  input  mem_tile_pkg::strb_t     be_i,
  input  mem_tile_pkg::data_t     wdata_i,
  input  mem_tile_pkg::mem_atop_e atop_i,
  input  mem_tile_pkg::id_t       aid_i,
  output logic                    rvalid_o,
  output mem_tile_pkg::data_t     rdata_o,
  output mem_tile_pkg::id_t       rid_o,
  mem_bank_if.mgr                 bank_o
);

  typedef enum logic {
    ST_IDLE,
    ST_WB
  } state_e;

  state_e state_q, state_d;

  logic accept, is_atomic, needs_wb, half, sc_hit;
  logic wb_write, wb_req_q;
  logic [mem_tile_pkg::AmoWordWidth-1:0] operand, operand_q, old_word, new_word;
  mem_tile_pkg::mem_atop_e op_q;
  mem_tile_pkg::addr_t     addr_q;
  mem_tile_pkg::id_t       rid_q;
  logic half_q, sc_ok_q;
  logic resv_valid_q;
  logic [mem_tile_pkg::AddrWidth-1:2] resv_addr_q;

  assign gnt_o     = (state_q == ST_IDLE);
  assign accept    = req_i & gnt_o;
  // Bit 2 picks the 32-bit half of the word
  assign half      = addr_i[2];
  assign is_atomic = (atop_i != mem_tile_pkg::ATOP_NONE);
  assign needs_wb  = is_atomic && (atop_i != mem_tile_pkg::ATOP_LR);
  assign sc_hit    = resv_valid_q && (resv_addr_q == addr_i[mem_tile_pkg::AddrWidth-1:2]);
  assign operand   = half ? wdata_i[mem_tile_pkg::AmoWordWidth +: mem_tile_pkg::AmoWordWidth]
                          : wdata_i[0 +: mem_tile_pkg::AmoWordWidth];

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: if (accept && needs_wb) state_d = ST_WB;
      ST_WB:   state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= ST_IDLE;
      wb_req_q     <= 1'b0;
      resv_valid_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      wb_req_q <= bank_o.req && (state_q == ST_WB);
      if (accept) begin
        if (atop_i == mem_tile_pkg::ATOP_LR) begin
          resv_valid_q <= 1'b1;
        end else if (atop_i == mem_tile_pkg::ATOP_SC) begin
          resv_valid_q <= 1'b0;
        end else if ((we_i || is_atomic) &&
                     (addr_i[mem_tile_pkg::AddrWidth-1:mem_tile_pkg::SramAddrWidthOffset] ==
                      resv_addr_q[mem_tile_pkg::AddrWidth-1:mem_tile_pkg::SramAddrWidthOffset]))
        begin
          resv_valid_q <= 1'b0;
        end
      end
    end
  end

  // Operands of the pending atomic and the echoed ID
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= atop_i;
      operand_q <= operand;
      half_q    <= half;
      addr_q    <= addr_i;
      sc_ok_q   <= sc_hit;
      rid_q     <= aid_i;
      if (atop_i == mem_tile_pkg::ATOP_LR) begin
        resv_addr_q <= addr_i[mem_tile_pkg::AddrWidth-1:2];
      end
    end
  end

  //////////////////////////////
  // Read-modify-write
  //////////////////////////////

  assign old_word = half_q ? bank_o.rdata[mem_tile_pkg::AmoWordWidth +: mem_tile_pkg::AmoWordWidth]
                           : bank_o.rdata[0 +: mem_tile_pkg::AmoWordWidth];

  always_comb begin
    case (op_q)
      mem_tile_pkg::ATOP_ADD:  new_word = old_word + operand_q;
      mem_tile_pkg::ATOP_AND:  new_word = old_word & operand_q;
      mem_tile_pkg::ATOP_OR:   new_word = old_word | operand_q;
      mem_tile_pkg::ATOP_XOR:  new_word = old_word ^ operand_q;
      mem_tile_pkg::ATOP_MAX:  new_word = ($signed(operand_q) > $signed(old_word)) ? operand_q
                                                                                   : old_word;
      mem_tile_pkg::ATOP_MAXU: new_word = (operand_q > old_word) ? operand_q : old_word;
      mem_tile_pkg::ATOP_MIN:  new_word = ($signed(operand_q) < $signed(old_word)) ? operand_q
                                                                                   : old_word;
      mem_tile_pkg::ATOP_MINU: new_word = (operand_q < old_word) ? operand_q : old_word;
      // Swap and SC store the operand
      default:                 new_word = operand_q;
    endcase
  end

  // A failed SC skips the write
  assign wb_write = (op_q != mem_tile_pkg::ATOP_SC) || sc_ok_q;

  always_comb begin
    if (state_q == ST_WB) begin
      bank_o.req   = wb_write;
      bank_o.we    = 1'b1;
      bank_o.addr  = addr_q;
      bank_o.wdata = {new_word, new_word};
      bank_o.be    = {{(mem_tile_pkg::StrbWidth/2){half_q}},
                      {(mem_tile_pkg::StrbWidth/2){~half_q}}};
    end else begin
      bank_o.req   = req_i;
      bank_o.we    = we_i && !is_atomic;
      bank_o.addr  = addr_i;
      bank_o.wdata = wdata_i;
      bank_o.be    = be_i;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // The write-back's own bank return is not a response
  assign rvalid_o = bank_o.rvalid && !wb_req_q;
  assign rid_o    = rid_q;

  always_comb begin
    rdata_o = bank_o.rdata;
    if ((state_q == ST_WB) && (op_q == mem_tile_pkg::ATOP_SC)) begin
      rdata_o = '0;
      rdata_o[half_q ? mem_tile_pkg::AmoWordWidth : 0] = ~sc_ok_q;
    end
  end

  no_accept_in_wb: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (accept && needs_wb) |=> !(req_i && gnt_o));

  no_atop_on_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (req_i && we_i) |-> (atop_i == mem_tile_pkg::ATOP_NONE));

endmodule

// ==== design/mem_bank_array.sv ====
// Bank array
// Splits each 64-bit word over two 32-bit banks and selects one of two
// macro rows per bank, read data returns one cycle after req

`timescale 1ns/1ps

module mem_bank_array (
  input  logic    clk_i,
  input  logic    arst_n_i,
  mem_bank_if.sbr bank_i
);

  logic [mem_tile_pkg::SramAddrWidth-1:0]     sram_addr;
  logic [mem_tile_pkg::SramMacroSelWidth-1:0] row_sel, row_sel_q;
  logic rvalid_q;

  logic [mem_tile_pkg::NumBanksPerWord-1:0][mem_tile_pkg::SramDataWidth-1:0]   sram_wdata;
  logic [mem_tile_pkg::NumBanksPerWord-1:0][mem_tile_pkg::SramDataWidth/8-1:0] sram_be;
  logic [mem_tile_pkg::NumBankRows-1:0][mem_tile_pkg::NumBanksPerWord-1:0]
        [mem_tile_pkg::SramDataWidth-1:0] sram_rdata;

  assign sram_addr = bank_i.addr[mem_tile_pkg::SramAddrWidthOffset +: mem_tile_pkg::SramAddrWidth];
  assign row_sel   = bank_i.addr[mem_tile_pkg::SramMacroSelOffset +:
                                 mem_tile_pkg::SramMacroSelWidth];

  // Row of the last read picks the return data
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      row_sel_q <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      rvalid_q <= bank_i.req;
      if (bank_i.req && !bank_i.we) begin
        row_sel_q <= row_sel;
      end
    end
  end

  assign bank_i.rvalid = rvalid_q;

  //////////////////////////////
  // Bank split
  //////////////////////////////

  for (genvar i = 0; i < mem_tile_pkg::NumBanksPerWord; i++) begin : gen_split
    assign sram_wdata[i] = bank_i.wdata[i*mem_tile_pkg::SramDataWidth +:
                                        mem_tile_pkg::SramDataWidth];
    assign sram_be[i]    = bank_i.be[i*mem_tile_pkg::SramDataWidth/8 +:
                                     mem_tile_pkg::SramDataWidth/8];
    assign bank_i.rdata[i*mem_tile_pkg::SramDataWidth +: mem_tile_pkg::SramDataWidth] =
        sram_rdata[row_sel_q][i];
  end

  for (genvar i = 0; i < mem_tile_pkg::NumBanksPerWord; i++) begin : gen_banks
    for (genvar j = 0; j < mem_tile_pkg::NumBankRows; j++) begin : gen_rows
      sram_macro i_sram (
        .clk_i   (clk_i),
        .req_i   (bank_i.req && (row_sel == mem_tile_pkg::SramMacroSelWidth'(j))),
        .we_i    (bank_i.we && (row_sel == mem_tile_pkg::SramMacroSelWidth'(j))),
        .addr_i  (sram_addr),
        .wdata_i (sram_wdata[i]),
        .be_i    (sram_be[i]),
        .rdata_o (sram_rdata[j][i])
      );
    end
  end

  rvalid_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bank_i.req |=> bank_i.rvalid);

  no_rvalid_without_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !bank_i.req |=> !bank_i.rvalid);

endmodule

// ==== design/mem_bank_if.sv ====
// Bank access interface
// One word access from the atomic unit to the bank array, no grant

`timescale 1ns/1ps

interface mem_bank_if;

  logic                  req;
  logic                  we;
  mem_tile_pkg::addr_t   addr;
  mem_tile_pkg::data_t   wdata;
  mem_tile_pkg::strb_t   be;
  logic                  rvalid;
  mem_tile_pkg::data_t   rdata;

  // Atomic unit side
  modport mgr (
    output req, we, addr, wdata, be,
    input  rvalid, rdata
  );

  // Bank array side, rvalid follows req by one cycle
  modport sbr (
    input  req, we, addr, wdata, be,
    output rvalid, rdata
  );

endinterface

// ==== design/mem_tile.sv ====
// Memory tile
// One 64-bit byte-addressed port with RISC-V atomics in front of a
// banked SRAM

`timescale 1ns/1ps

module mem_tile (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  // Request
  input  logic                    req_i,
  output logic                    gnt_o,
  input  mem_tile_pkg::addr_t     addr_i,
  input  logic                    we_i,
  input  mem_tile_pkg::strb_t     be_i,
  input  mem_tile_pkg::data_t     wdata_i,
  input  mem_tile_pkg::mem_atop_e atop_i,
  input  mem_tile_pkg::id_t       aid_i,
  // Response
  output logic                    rvalid_o,
  output mem_tile_pkg::data_t     rdata_o,
  output mem_tile_pkg::id_t       rid_o
);

  mem_bank_if bank_bus ();

  mem_atomic_unit i_atomic_unit (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .addr_i   (addr_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .wdata_i  (wdata_i),
    .atop_i   (atop_i),
    .aid_i    (aid_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .rid_o    (rid_o),
    .bank_o   (bank_bus)
  );

  mem_bank_array i_bank_array (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bank_i   (bank_bus)
  );

endmodule

// ==== design/mem_tile_pkg.sv ====
// Memory tile package
// Geometry of the banked SRAM, atomic opcodes and the shared port types

package mem_tile_pkg;

  //////////////////////////////
  // Geometry
  //////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;

  // Each port word is split across two 32-bit banks
  localparam int unsigned NumBanksPerWord     = 2;
  localparam int unsigned SramDataWidth       = DataWidth / NumBanksPerWord;
  localparam int unsigned NumBankRows         = 2;
  localparam int unsigned SramNumWords        = 256;
  localparam int unsigned SramAddrWidth       = $clog2(SramNumWords);
  localparam int unsigned SramAddrWidthOffset = $clog2(StrbWidth);
  localparam int unsigned SramMacroSelOffset  = SramAddrWidthOffset + SramAddrWidth;
  localparam int unsigned SramMacroSelWidth   = $clog2(NumBankRows);

  // RISC-V atomics work on 32-bit words
  localparam int unsigned AmoWordWidth = 32;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef enum logic [3:0] {
    ATOP_NONE = 4'd0,
    ATOP_SWAP = 4'd1,
    ATOP_ADD  = 4'd2,
    ATOP_AND  = 4'd3,
    ATOP_OR   = 4'd4,
    ATOP_XOR  = 4'd5,
    ATOP_MAX  = 4'd6,
    ATOP_MAXU = 4'd7,
    ATOP_MIN  = 4'd8,
    ATOP_MINU = 4'd9,
    ATOP_LR   = 4'd10,
    ATOP_SC   = 4'd11
  } mem_atop_e;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [IdWidth-1:0]   id_t;

endpackage

// ==== design/sram_macro.sv ====
// Single-port SRAM macro
// Behavioral model with byte enables and one cycle of read latency

`timescale 1ns/1ps

module sram_macro (
  input  logic                                    clk_i,
  input  logic                                    req_i,
  input  logic                                    we_i,
  input  logic [mem_tile_pkg::SramAddrWidth-1:0]  addr_i,
  input  logic [mem_tile_pkg::SramDataWidth-1:0]  wdata_i,
  input  logic [mem_tile_pkg::SramDataWidth/8-1:0] be_i,
  output logic [mem_tile_pkg::SramDataWidth-1:0]  rdata_o
);

  logic [mem_tile_pkg::SramDataWidth-1:0] mem_q [mem_tile_pkg::SramNumWords];

  // Read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < mem_tile_pkg::SramDataWidth/8; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

// ==== mem_tile.f ====
design/mem_tile_pkg.sv
design/mem_bank_if.sv
design/sram_macro.sv
design/mem_atomic_unit.sv
design/mem_bank_array.sv
design/mem_tile.sv
verification/mem_tile_tb.sv

// ==== verification/mem_tile_tb.sv ====
// Memory tile testbench
// Plain accesses, both macro rows, every AMO and LR/SC against a reference
// memory, with the port protocol checked by concurrent assertions

`timescale 1ns/1ps

module mem_tile_tb;

  logic                    clk_i = 1'b0;
  logic                    arst_n_i;
  logic                    req_i;
  logic                    gnt_o;
  mem_tile_pkg::addr_t     addr_i;
  logic                    we_i;
  mem_tile_pkg::strb_t     be_i;
  mem_tile_pkg::data_t     wdata_i;
  mem_tile_pkg::mem_atop_e atop_i;
  mem_tile_pkg::id_t       aid_i;
  logic                    rvalid_o;
  mem_tile_pkg::data_t     rdata_o;
  mem_tile_pkg::id_t       rid_o;

  // Reference memory, indexed by word
  mem_tile_pkg::data_t model [int unsigned];
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_start_errors;
  string test_name;
  bit hung = 1'b0;

  always #2 clk_i = ~clk_i;

  mem_tile i_dut (.*);

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  wire accept = req_i && gnt_o;
  wire wb_op  = (atop_i != mem_tile_pkg::ATOP_NONE) && (atop_i != mem_tile_pkg::ATOP_LR);

  task automatic note_failure(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  response_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |=> rvalid_o)
    else note_failure("missing response one cycle after acceptance");

  no_spurious_response: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !accept |=> !rvalid_o)
    else note_failure("rvalid_o high without an accepted request");

  grant_drops_once: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (accept && wb_op) |=> !gnt_o ##1 gnt_o)
    else note_failure("gnt_o not low for exactly one cycle after AMO or SC");

  grant_stays_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (gnt_o && !(accept && wb_op)) |=> gnt_o)
    else note_failure("gnt_o dropped without an AMO or SC");

  state_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> (gnt_o && !rvalid_o))
    else note_failure("gnt_o low or rvalid_o high right after reset");

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int unsigned word_index(input mem_tile_pkg::addr_t a);
    return a[mem_tile_pkg::SramMacroSelOffset:mem_tile_pkg::SramAddrWidthOffset];
  endfunction

  function automatic mem_tile_pkg::data_t merge_bytes(input mem_tile_pkg::data_t old,
      input mem_tile_pkg::data_t wdata, input mem_tile_pkg::strb_t be);
    mem_tile_pkg::data_t res;
    res = old;
    for (int b = 0; b < mem_tile_pkg::StrbWidth; b++) begin
      if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] amo_expect(input mem_tile_pkg::mem_atop_e op,
      input logic [31:0] old, input logic [31:0] opnd);
    case (op)
      mem_tile_pkg::ATOP_ADD:  return old + opnd;
      mem_tile_pkg::ATOP_AND:  return old & opnd;
      mem_tile_pkg::ATOP_OR:   return old | opnd;
      mem_tile_pkg::ATOP_XOR:  return old ^ opnd;
      mem_tile_pkg::ATOP_MAX:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      mem_tile_pkg::ATOP_MIN:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      mem_tile_pkg::ATOP_MAXU: return (old > opnd) ? old : opnd;
      mem_tile_pkg::ATOP_MINU: return (old < opnd) ? old : opnd;
      default:                 return opnd;
    endcase
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic check_value(input string name, input mem_tile_pkg::data_t exp,
      input mem_tile_pkg::data_t act);
    assert (hung || act === exp) else begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Called 0.5 ns after a rising edge, returns at the same point
  task automatic issue(input mem_tile_pkg::addr_t addr, input logic we,
      input mem_tile_pkg::strb_t be, input mem_tile_pkg::data_t wdata,
      input mem_tile_pkg::mem_atop_e atop, output mem_tile_pkg::data_t rdata);
    int waited;
    mem_tile_pkg::id_t id;
    rdata = '0;
    if (hung) return;
    id      = mem_tile_pkg::id_t'($urandom);
    req_i   = 1'b1;
    addr_i  = addr;
    we_i    = we;
    be_i    = be;
    wdata_i = wdata;
    atop_i  = atop;
    aid_i   = id;
    waited  = 0;
    while (!gnt_o && waited < 50) begin
      @(posedge clk_i);
      #0.5;
      waited++;
    end
    if (!gnt_o) begin
      hung = 1'b1;
      req_i = 1'b0;
      note_failure("timeout waiting for gnt_o");
      return;
    end
    @(posedge clk_i);
    #0.5;
    req_i  = 1'b0;
    atop_i = mem_tile_pkg::ATOP_NONE;
    waited = 0;
    while (!rvalid_o && waited < 50) begin
      @(posedge clk_i);
      #0.5;
      waited++;
    end
    if (!rvalid_o) begin
      hung = 1'b1;
      note_failure("timeout waiting for rvalid_o");
      return;
    end
    rdata = rdata_o;
    check_value({test_name, " rid_o"}, mem_tile_pkg::data_t'(id),
                mem_tile_pkg::data_t'(rid_o));
  endtask

  task automatic write_word(input mem_tile_pkg::addr_t addr, input mem_tile_pkg::strb_t be,
      input mem_tile_pkg::data_t wdata);
    mem_tile_pkg::data_t unused;
    issue(addr, 1'b1, be, wdata, mem_tile_pkg::ATOP_NONE, unused);
    model[word_index(addr)] = merge_bytes(model[word_index(addr)], wdata, be);
  endtask

  task automatic read_check(input string name, input mem_tile_pkg::addr_t addr);
    mem_tile_pkg::data_t rd;
    issue(addr, 1'b0, '1, '0, mem_tile_pkg::ATOP_NONE, rd);
    check_value(name, model[word_index(addr)], rd);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_start_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_start_errors) begin
      tests_failed++;
      $display("test %s: failed", test_name);
    end else begin
      $display("test %s: passed", test_name);
    end
  endtask

  initial begin
    mem_tile_pkg::addr_t addrs [8];
    mem_tile_pkg::mem_atop_e ops [9];
    mem_tile_pkg::addr_t a;
    mem_tile_pkg::data_t rd, init;
    logic [31:0] old_half, opnd;
    string name;

    void'($urandom(32'h0c40_6234));
    ops = '{mem_tile_pkg::ATOP_SWAP, mem_tile_pkg::ATOP_ADD,
        mem_tile_pkg::ATOP_AND, mem_tile_pkg::ATOP_OR, mem_tile_pkg::ATOP_XOR,
        mem_tile_pkg::ATOP_MAX, mem_tile_pkg::ATOP_MAXU, mem_tile_pkg::ATOP_MIN,
        mem_tile_pkg::ATOP_MINU};
    arst_n_i = 1'b0;
    req_i    = 1'b0;
    addr_i   = '0;
    we_i     = 1'b0;
    be_i     = '0;
    wdata_i  = '0;
    atop_i   = mem_tile_pkg::ATOP_NONE;
    aid_i    = '0;
    repeat (16) @(posedge clk_i);
    #0.5;
    arst_n_i = 1'b1;

    // Full write first so no byte is left uninitialized
    begin_test("rand_write_read");
    for (int i = 0; i < 8; i++) begin
      addrs[i] = {20'd0, 6'($urandom), 3'(i), 3'd0};
      write_word(addrs[i], '1, {$urandom, $urandom});
      write_word(addrs[i], mem_tile_pkg::strb_t'($urandom), {$urandom, $urandom});
    end
    for (int i = 0; i < 8; i++) read_check("rand_write_read", addrs[i]);
    end_test();

    begin_test("row_select");
    a = 32'h0000_00a8;
    write_word(a, '1, 64'h0123_4567_89ab_cdef);
    write_word(a | (32'd1 << mem_tile_pkg::SramMacroSelOffset), '1, 64'hfedc_ba98_7654_3210);
    read_check("row_select", a);
    read_check("row_select", a | (32'd1 << mem_tile_pkg::SramMacroSelOffset));
    end_test();

    begin_test("amo_ops");
    for (int o = 0; o < 9; o++) begin
      for (int h = 0; h < 2; h++) begin
        a = 32'h0000_0400 + 32'(8 * (2 * o + h) + 4 * h);
        name = $sformatf("amo_%s_half%0d", ops[o].name(), h);
        init = {$urandom, $urandom};
        write_word(a, '1, init);
        old_half = h ? init[63:32] : init[31:0];
        // Operand of opposite sign to the stored value
        opnd = $urandom;
        opnd[31] = ~old_half[31];
        issue(a, 1'b0, '0, h ? {opnd, 32'($urandom)} : {32'($urandom), opnd}, ops[o], rd);
        check_value(name, init, rd);
        model[word_index(a)][h*32 +: 32] = amo_expect(ops[o], old_half, opnd);
        read_check(name, a);
      end
    end
    end_test();

    begin_test("lr_sc_pass");
    a = 32'h0000_0810;
    init = {$urandom, $urandom};
    write_word(a, '1, init);
    issue(a, 1'b0, '0, '0, mem_tile_pkg::ATOP_LR, rd);
    check_value("lr_sc_pass", init, rd);
    opnd = $urandom;
    issue(a, 1'b0, '0, {32'd0, opnd}, mem_tile_pkg::ATOP_SC, rd);
    check_value("lr_sc_pass", 64'd0, rd);
    model[word_index(a)][31:0] = opnd;
    read_check("lr_sc_pass", a);
    end_test();

    // The SC above consumed the reservation
    begin_test("sc_no_lr");
    issue(a, 1'b0, '0, {32'd0, 32'($urandom)}, mem_tile_pkg::ATOP_SC, rd);
    check_value("sc_no_lr", 64'd1, rd);
    read_check("sc_no_lr", a);
    end_test();

    begin_test("lr_write_sc");
    issue(a + 32'd4, 1'b0, '0, '0, mem_tile_pkg::ATOP_LR, rd);
    write_word(a, '1, {$urandom, $urandom});
    issue(a + 32'd4, 1'b0, '0, {32'($urandom), 32'd0}, mem_tile_pkg::ATOP_SC, rd);
    check_value("lr_write_sc", 64'd1 << 32, rd);
    read_check("lr_write_sc", a);
    end_test();

    repeat (3) @(posedge clk_i);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && !hung) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
